/* hdl/mem_bus_consts.svh */
`ifndef MEM_BUS_CONSTS_SVH
`define MEM_BUS_CONSTS_SVH

// Sizes shared by the memory bus port

// Data word as carried on the SBUS
// 36 bits, parity travels beside it
`define MEM_WORD_BITS 36

// Physical memory address
// 22 bits, parity travels beside it
`define MEM_ADR_BITS 22

// Words of storage behind the bus
// Addresses at or above this are nonexistent memory
`define MEM_WORDS 256

// Index into storage, matches MEM_WORDS
`define MEM_IDX_BITS 8

// Translator request queue depth
// Also the number of credits the requester starts with
`define MEM_QUEUE_DEPTH 2

`endif

/* hdl/mem_bus_pkg.sv */
`include "mem_bus_consts.svh"

package mem_bus_pkg;

  // Meaningful widths
  typedef logic [`MEM_WORD_BITS-1:0] word_t;
  typedef logic [`MEM_ADR_BITS-1:0]  pma_t;
  typedef logic [`MEM_IDX_BITS-1:0]  mem_idx_t;

  // Operation requested by the processor side
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // Status reported once per operation
  // Listed in order of decreasing priority after ok
  typedef enum logic [1:0] {
    st_ok           = 2'd0,
    st_adr_par_err  = 2'd1,
    st_nxm          = 2'd2,
    st_data_par_err = 2'd3
  } mem_status_e;

  // Translator cycle states
  // Start is the first cycle of sbus_start, hold waits for the acknowledge
  typedef enum logic [1:0] {
    xlat_idle  = 2'd0,
    xlat_start = 2'd1,
    xlat_hold  = 2'd2
  } xlat_state_e;

  // Request from the processor side
  // Both parity bits are odd parity, supplied by the requester
  typedef struct packed {
    mem_op_e op;
    pma_t    pma;
    logic    adr_par;
    word_t   data;
    logic    data_par;
  } mem_req_t;

  // One SBUS memory cycle as driven by the translator
  // d and data_par are only driven toward memory on writes
  typedef struct packed {
    logic  rd_rq;
    logic  wr_rq;
    pma_t  adr;
    logic  adr_par;
    word_t d;
    logic  data_par;
  } sbus_cmd_t;

  // Memory reply for one cycle
  typedef struct packed {
    logic  rd;
    word_t d;
    logic  data_par;
    logic  adr_par_err;
    logic  mem_error;
  } sbus_rsp_t;

  // Response back to the requester
  typedef struct packed {
    mem_status_e status;
    word_t       data;
  } mem_rsp_t;

endpackage

/* hdl/mt0_translator.sv */
`include "mem_bus_consts.svh"

module mt0_translator (
  input  logic                   sbus_clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  mem_bus_pkg::mem_req_t  req,
  output logic                   sbus_start,
  output mem_bus_pkg::sbus_cmd_t cmd,
  input  logic                   sbus_ack
);
  import mem_bus_pkg::*;

  localparam int PTR_BITS = (`MEM_QUEUE_DEPTH > 1) ? $clog2(`MEM_QUEUE_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(`MEM_QUEUE_DEPTH + 1);

  typedef logic [PTR_BITS-1:0] ptr_t;
  typedef logic [CNT_BITS-1:0] cnt_t;

  mem_req_t    fifo_q [`MEM_QUEUE_DEPTH];
  ptr_t        wr_ptr_q;
  ptr_t        rd_ptr_q;
  cnt_t        count_q;
  logic        push;
  logic        pop;
  logic        has_next;
  logic        load_cmd;
  mem_req_t    head;
  mem_req_t    next_head;
  mem_req_t    load_src;
  xlat_state_e state_q;
  sbus_cmd_t   cmd_q;

  // Queue pointer advance with wrap at the queue depth
  function automatic ptr_t next_ptr(ptr_t p);
    ptr_t n;
    if (p == ptr_t'(`MEM_QUEUE_DEPTH - 1)) begin
      n = '0;
    end else begin
      n = p + ptr_t'(1);
    end
    return n;
  endfunction

  // Turn a queued request into SBUS request lines
  // Data drivers face the memory only on writes, as the MT0 direction switch does
  function automatic sbus_cmd_t decode(mem_req_t r);
    sbus_cmd_t c;
    logic      data_to_mem;
    data_to_mem = (r.op == op_write);
    c.rd_rq     = (r.op == op_read);
    c.wr_rq     = data_to_mem;
    c.adr       = r.pma;
    // Address parity goes to memory unchecked
    c.adr_par   = r.adr_par;
    c.d         = data_to_mem ? r.data : '0;
    c.data_par  = data_to_mem ? r.data_par : 1'b0;
    return c;
  endfunction

  // Credits keep the queue from overflowing
  assign push = req_valid && (count_q != cnt_t'(`MEM_QUEUE_DEPTH));

  // Entry leaves the queue on the acknowledge
  assign pop = (state_q != xlat_idle) && sbus_ack;

  // Another entry already waits behind the one being acknowledged
  assign has_next = (count_q > cnt_t'(1));

  assign head      = fifo_q[rd_ptr_q];
  assign next_head = fifo_q[next_ptr(rd_ptr_q)];

  // Held address loads at the start of each cycle
  // From idle the head starts, after an acknowledge the entry behind it
  assign load_cmd = ((state_q == xlat_idle) && (count_q != '0)) || (pop && has_next);
  assign load_src = (state_q == xlat_idle) ? head : next_head;

  // Queue storage
  always_ff @(posedge sbus_clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= req;
    end
  end

  // Queue pointers and occupancy
  always_ff @(posedge sbus_clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Cycle FSM
  always_ff @(posedge sbus_clk) begin
    if (!rst_n) begin
      state_q <= xlat_idle;
    end else begin
      case (state_q)
        xlat_idle: begin
          if (count_q != '0) begin
            state_q <= xlat_start;
          end
        end
        xlat_start, xlat_hold: begin
          // Back-to-back start when the next entry is already queued
          if (sbus_ack) begin
            state_q <= has_next ? xlat_start : xlat_idle;
          end else begin
            state_q <= xlat_hold;
          end
        end
        default: state_q <= xlat_idle;
      endcase
    end
  end

  // Held command register, stands in for the MT03 address latch
  always_ff @(posedge sbus_clk) begin
    if (load_cmd) begin
      cmd_q <= decode(load_src);
    end
  end

  // Start stays up from the start state until the acknowledge
  assign sbus_start = (state_q != xlat_idle);
  assign cmd        = cmd_q;

endmodule

/* hdl/sbus_memory.sv */
`include "mem_bus_consts.svh"

module sbus_memory (
  input  logic                   sbus_clk,
  input  logic                   rst_n,
  input  logic                   sbus_start,
  input  mem_bus_pkg::sbus_cmd_t cmd,
  output logic                   sbus_ack,
  output logic                   sbus_data_valid,
  output mem_bus_pkg::sbus_rsp_t mrsp
);
  import mem_bus_pkg::*;

  // Word storage with its parity bit
  word_t                 mem_q [`MEM_WORDS];
  logic                  par_q [`MEM_WORDS];
  // Words written since reset, the rest read as zero
  logic [`MEM_WORDS-1:0] written_q;

  logic      accept;
  mem_idx_t  cmd_idx;
  logic      cmd_adr_err;
  logic      cmd_nxm;
  logic      cmd_store;
  logic      ack_q;
  logic      dv_q;
  logic      rd_q;
  mem_idx_t  idx_q;
  logic      adr_err_q;
  logic      nxm_q;
  logic      rd_hit;
  sbus_rsp_t mrsp_q;

  // New start is taken once the previous acknowledge has dropped
  assign accept = sbus_start && !ack_q;

  assign cmd_idx = cmd.adr[`MEM_IDX_BITS-1:0];

  // Odd parity over address and parity bit
  assign cmd_adr_err = ~^{cmd.adr, cmd.adr_par};

  // Nonexistent memory above the installed words
  assign cmd_nxm = (cmd.adr >= pma_t'(`MEM_WORDS));

  // Only a clean, in-range write changes storage
  assign cmd_store = accept && cmd.wr_rq && !cmd_adr_err && !cmd_nxm;

  // Acknowledge one cycle after start, data valid one cycle after that
  always_ff @(posedge sbus_clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      dv_q  <= 1'b0;
    end else begin
      ack_q <= accept;
      dv_q  <= ack_q;
    end
  end

  // Cycle state carried from acknowledge into the data stage
  always_ff @(posedge sbus_clk) begin
    if (accept) begin
      rd_q      <= cmd.rd_rq;
      idx_q     <= cmd_idx;
      adr_err_q <= cmd_adr_err;
      nxm_q     <= cmd_nxm;
    end
  end

  // Write port, parity stored as supplied
  always_ff @(posedge sbus_clk) begin
    if (cmd_store) begin
      mem_q[cmd_idx] <= cmd.d;
      par_q[cmd_idx] <= cmd.data_par;
    end
  end

  always_ff @(posedge sbus_clk) begin
    if (!rst_n) begin
      written_q <= '0;
    end else if (cmd_store) begin
      written_q[cmd_idx] <= 1'b1;
    end
  end

  // Read returns storage only for a clean, in-range, written word
  assign rd_hit = rd_q && !adr_err_q && !nxm_q && written_q[idx_q];

  // Reply register, filled in the acknowledge cycle
  // Empty words and writes reply zero with good parity
  always_ff @(posedge sbus_clk) begin
    if (ack_q) begin
      mrsp_q.rd          <= rd_q;
      mrsp_q.d           <= rd_hit ? mem_q[idx_q] : '0;
      mrsp_q.data_par    <= rd_hit ? par_q[idx_q] : 1'b1;
      mrsp_q.adr_par_err <= adr_err_q;
      mrsp_q.mem_error   <= nxm_q;
    end
  end

  assign sbus_ack        = ack_q;
  assign sbus_data_valid = dv_q;
  assign mrsp            = mrsp_q;

endmodule

/* hdl/mem_result.sv */
module mem_result (
  input  logic                   sbus_clk,
  input  logic                   rst_n,
  input  logic                   sbus_data_valid,
  input  mem_bus_pkg::sbus_rsp_t mrsp,
  output logic                   rsp_valid,
  output mem_bus_pkg::mem_rsp_t  rsp,
  output logic                   credit_return
);
  import mem_bus_pkg::*;

  mem_status_e status;
  word_t       data;
  logic        data_par_bad;
  logic        pass_data;
  logic        valid_q;
  mem_rsp_t    rsp_q;

  // Read data must carry odd parity
  assign data_par_bad = mrsp.rd && !(^{mrsp.d, mrsp.data_par});

  // Status priority
  // Address parity, then nonexistent memory, then data parity
  always_comb begin
    if (mrsp.adr_par_err) begin
      status = st_adr_par_err;
    end else if (mrsp.mem_error) begin
      status = st_nxm;
    end else if (data_par_bad) begin
      status = st_data_par_err;
    end else begin
      status = st_ok;
    end
  end

  // Read word goes out on success and on a data parity error
  assign pass_data = mrsp.rd && ((status == st_ok) || (status == st_data_par_err));
  assign data      = pass_data ? mrsp.d : '0;

  // One response and one credit per memory reply
  always_ff @(posedge sbus_clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sbus_data_valid;
    end
  end

  always_ff @(posedge sbus_clk) begin
    if (sbus_data_valid) begin
      rsp_q.status <= status;
      rsp_q.data   <= data;
    end
  end

  assign rsp_valid     = valid_q;
  // Credit goes back in the same cycle as the response
  assign credit_return = valid_q;
  assign rsp           = rsp_q;

endmodule

/* hdl/mem_bus_top.sv */
module mem_bus_top (
  input  logic                  sbus_clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  mem_bus_pkg::mem_req_t req,
  output logic                  credit_return,
  output logic                  rsp_valid,
  output mem_bus_pkg::mem_rsp_t rsp
);
  import mem_bus_pkg::*;

  // Translator to memory
  logic      sbus_start;
  logic      sbus_ack;
  sbus_cmd_t cmd;

  // Memory to result stage
  logic      sbus_data_valid;
  sbus_rsp_t mrsp;

  // Decode, queues requests and runs start/acknowledge cycles
  mt0_translator i_mt0_translator (
    .sbus_clk   (sbus_clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .sbus_start (sbus_start),
    .cmd        (cmd),
    .sbus_ack   (sbus_ack)
  );

  // Execute, storage with address checks
  sbus_memory i_sbus_memory (
    .sbus_clk        (sbus_clk),
    .rst_n           (rst_n),
    .sbus_start      (sbus_start),
    .cmd             (cmd),
    .sbus_ack        (sbus_ack),
    .sbus_data_valid (sbus_data_valid),
    .mrsp            (mrsp)
  );

  // Result, parity check, status and credit return
  mem_result i_mem_result (
    .sbus_clk        (sbus_clk),
    .rst_n           (rst_n),
    .sbus_data_valid (sbus_data_valid),
    .mrsp            (mrsp),
    .rsp_valid       (rsp_valid),
    .rsp             (rsp),
    .credit_return   (credit_return)
  );

endmodule

/* tests/mem_bus_tb.sv */
`include "mem_bus_consts.svh"

module mem_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_bus_pkg::*;

  localparam int DEPTH      = `MEM_QUEUE_DEPTH;
  localparam int WAIT_LIMIT = 100;
  localparam int BURST_OPS  = 300;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     req_valid;
  mem_req_t req;
  logic     credit_return;
  logic     rsp_valid;
  mem_rsp_t rsp;

  // Reference storage, starts as zero words with parity 1
  word_t    model_data [`MEM_WORDS];
  logic     model_par  [`MEM_WORDS];
  // Expected responses in acceptance order
  mem_rsp_t exp_q[$];
  mem_rsp_t exp_head;
  int       exp_count = 0;
  int       credits   = DEPTH;
  int       issued    = 0;
  int       returned  = 0;

  mem_bus_top i_mem_bus_top (
    .sbus_clk      (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at %0t ns", $time);
  endtask

  // Odd parity on address and data, either one can be spoiled on purpose
  function automatic mem_req_t make_req(mem_op_e op, pma_t pma, word_t data,
                                        logic bad_adr_par, logic bad_data_par);
    mem_req_t r;
    r.op       = op;
    r.pma      = pma;
    r.adr_par  = (~^pma) ^ bad_adr_par;
    r.data     = data;
    r.data_par = (~^data) ^ bad_data_par;
    return r;
  endfunction

  function automatic word_t random_word();
    return word_t'({$urandom(), $urandom()});
  endfunction

  // Mostly a small window of real words, some nxm, a few parity faults
  function automatic mem_req_t random_req();
    pma_t pma;
    pma = pma_t'($urandom_range(0, 31));
    if ($urandom_range(0, 7) == 0) begin
      pma = pma_t'(`MEM_WORDS + $urandom_range(0, 1023));
    end
    return make_req($urandom_range(0, 1) ? op_write : op_read, pma, random_word(),
                    $urandom_range(0, 15) == 0, $urandom_range(0, 15) == 0);
  endfunction

  // Status priority is address parity, then nxm, then read data parity
  // Only a clean in-range write changes the model
  function automatic mem_rsp_t predict(mem_req_t r);
    mem_rsp_t e;
    mem_idx_t idx;
    idx    = r.pma[`MEM_IDX_BITS-1:0];
    e.data = '0;
    if (^{r.pma, r.adr_par} == 1'b0) begin
      e.status = st_adr_par_err;
    end else if (r.pma >= pma_t'(`MEM_WORDS)) begin
      e.status = st_nxm;
    end else if (r.op == op_write) begin
      e.status        = st_ok;
      model_data[idx] = r.data;
      model_par[idx]  = r.data_par;
    end else begin
      e.data   = model_data[idx];
      e.status = (^{model_data[idx], model_par[idx]}) ? st_ok : st_data_par_err;
    end
    return e;
  endfunction

  // Tracks what the DUT sampled at this edge
  // Acceptance pushes a prediction, a response pops the head
  always @(posedge clk) begin
    if (!rst_n) begin
      credits  <= DEPTH;
      issued   <= 0;
      returned <= 0;
    end else begin
      if (rsp_valid && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (req_valid) begin
        exp_q.push_back(predict(req));
        issued <= issued + 1;
      end
      if (credit_return) begin
        returned <= returned + 1;
      end
      credits <= credits - (req_valid ? 1 : 0) + (credit_return ? 1 : 0);
    end
    exp_count <= exp_q.size();
    if (exp_q.size() != 0) begin
      exp_head <= exp_q[0];
    end else begin
      exp_head <= '0;
    end
  end

  // Checks run on the falling edge, when DUT outputs are settled
  quiet_in_reset: assert property (@(negedge clk) !rst_n |-> !rsp_valid && !credit_return)
    else begin
      $display("[ERROR] %0t ns rsp_valid,credit_return expected 0,0 got %0b,%0b",
               $time, rsp_valid, credit_return);
      abort_run();
    end

  rsp_matches: assert property (@(negedge clk) disable iff (!rst_n)
      rsp_valid |-> rsp == exp_head)
    else begin
      $display("[ERROR] %0t ns rsp expected %h got %h", $time, exp_head, rsp);
      abort_run();
    end

  credit_with_rsp: assert property (@(negedge clk) disable iff (!rst_n)
      credit_return == rsp_valid)
    else begin
      $display("[ERROR] %0t ns credit_return expected %0b got %0b",
               $time, rsp_valid, credit_return);
      abort_run();
    end

  // Nothing comes back unless something was accepted
  rsp_expected: assert property (@(negedge clk) disable iff (!rst_n)
      rsp_valid |-> exp_count > 0)
    else begin
      $display("Response arrived with no operation outstanding at %0t ns", $time);
      abort_run();
    end

  within_depth: assert property (@(negedge clk) disable iff (!rst_n)
      exp_count <= DEPTH && credits >= 0)
    else begin
      $display("More than %0d operations outstanding at %0t ns", DEPTH, $time);
      abort_run();
    end

  // Waits for a credit, then drives the request for one cycle
  task automatic issue(input mem_req_t r);
    int waited;
    int avail;
    waited = 0;
    avail  = 0;
    while (avail <= 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      // Credits as they stand after this edge
      avail = credits - (req_valid ? 1 : 0) + (credit_return ? 1 : 0);
      if (avail > 0) begin
        req       <= r;
        req_valid <= 1'b1;
      end else begin
        req_valid <= 1'b0;
        waited++;
      end
    end
    if (avail <= 0) begin
      $display("Timed out waiting for a credit");
      abort_run();
    end
  endtask

  task automatic release_bus();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((exp_count != 0 || credits != DEPTH) && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (exp_count != 0 || credits != DEPTH) begin
      $display("Timed out waiting for the pipe to drain");
      abort_run();
    end
  endtask

  // Single operation on an empty pipe, counts cycles from acceptance
  task automatic timed_op(input mem_req_t r);
    int lat;
    wait_idle();
    issue(r);
    // This edge accepts the request
    release_bus();
    lat = 0;
    @(negedge clk);
    while (!rsp_valid && lat < WAIT_LIMIT) begin
      lat++;
      @(negedge clk);
    end
    if (!rsp_valid) begin
      $display("Timed out waiting for rsp_valid");
      abort_run();
    end else begin
      latency_is_four: assert (lat == 4)
        else begin
          $display("[ERROR] %0t ns rsp_valid latency expected 4 got %0d", $time, lat);
          abort_run();
        end
    end
  endtask

  initial begin
    pma_t  a;
    word_t w;
    void'($urandom(34));
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_data[i] = '0;
      model_par[i]  = 1'b1;
    end
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Idle after reset, nothing may come back
    repeat (20) @(posedge clk);

    // Unwritten word, then write/read pairs
    timed_op(make_req(op_read, pma_t'($urandom_range(0, 255)), '0, 1'b0, 1'b0));
    for (int n = 0; n < 8; n++) begin
      a = pma_t'($urandom_range(0, 255));
      timed_op(make_req(op_write, a, random_word(), 1'b0, 1'b0));
      timed_op(make_req(op_read, a, '0, 1'b0, 1'b0));
    end

    // Bad address parity leaves the old word in place
    a = pma_t'($urandom_range(0, 255));
    w = random_word();
    timed_op(make_req(op_write, a, w, 1'b0, 1'b0));
    timed_op(make_req(op_write, a, ~w, 1'b1, 1'b0));
    timed_op(make_req(op_read, a, '0, 1'b1, 1'b0));
    timed_op(make_req(op_read, a, '0, 1'b0, 1'b0));

    // Nonexistent memory
    a = pma_t'(`MEM_WORDS + $urandom_range(0, 4095));
    timed_op(make_req(op_write, a, random_word(), 1'b0, 1'b0));
    timed_op(make_req(op_read, a, '0, 1'b0, 1'b0));

    // Even data parity is stored as given and flagged on read
    a = pma_t'($urandom_range(0, 255));
    timed_op(make_req(op_write, a, random_word(), 1'b0, 1'b1));
    timed_op(make_req(op_read, a, '0, 1'b0, 1'b0));

    // Back-to-back random traffic at full credit
    for (int n = 0; n < BURST_OPS; n++) begin
      issue(random_req());
    end
    release_bus();
    wait_idle();

    if (issued == returned && credits == DEPTH) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("Credits unbalanced, %0d issued and %0d returned", issued, returned);
      abort_run();
    end
  end

endmodule

/* build.f */
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/mt0_translator.sv
hdl/sbus_memory.sv
hdl/mem_result.sv
hdl/mem_bus_top.sv
tests/mem_bus_tb.sv

/* Makefile */
SIM        := verilator
TOP        := mem_bus_tb
RTL_TOP    := mem_bus_top
FILELIST   := build.f
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
